//--- verilog/uart_rx_pkg.sv
// Fixed 16x oversampling; cfg must stay stable while a character is on the line
`default_nettype none

package uart_rx_pkg;

  // --------------------
  // Oversampling
  // --------------------
  localparam int OVERSAMPLE         = 16; // Ticks per bit
  localparam int SAMPLE_START_PHASE = 5;  // First majority sample
  localparam int SAMPLE_END_PHASE   = 7;  // Last majority sample
  localparam int CENTER_PHASE       = 8;  // Bit centre
  localparam int START_LOAD_PHASE   = 2;  // Offset for late edge detection

  localparam int DIV_W = 16; // Tick divisor width

  // --------------------
  // Configuration
  // --------------------
  typedef enum logic [1:0] {
    PAR_ODD    = 2'b00,
    PAR_EVEN   = 2'b01,
    PAR_FORCE1 = 2'b10,
    PAR_FORCE0 = 2'b11
  } par_mode_e;

  typedef enum logic [1:0] {LEN5, LEN6, LEN7, LEN8} word_len_e;

  typedef enum logic [1:0] {TRIG1, TRIG4, TRIG8, TRIG14} trig_level_e;

  typedef struct packed {
    logic [DIV_W-1:0] divisor;    // Clocks per oversample tick, >= 2
    word_len_e        word_len;
    logic             par_en;
    par_mode_e        par_mode;
    trig_level_e      trig_level;
  } rx_cfg_t;

  // Sampler to framer
  typedef struct packed {
    logic center; // One-clock strobe at bit centre
    logic value;  // Majority-filtered line
  } rx_sample_t;

  // FIFO word, flags on top
  typedef struct packed {
    logic       par_err;
    logic       frame_err;
    logic       brk;
    logic [7:0] data; // Unused upper bits zero
  } rx_char_t;

  typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP, RESYNC} rx_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_rx_tick_gen.sv
// Divisor must be at least 2; a new divisor applies after the current period
`timescale 1ns/1ns
`default_nettype none

module uart_rx_tick_gen (
  input  wire logic                           clk_i,
  input  wire logic                           rst_i,
  input  wire logic [uart_rx_pkg::DIV_W-1:0]  divisor_i,
  output logic                                tick_o
);
  import uart_rx_pkg::*;

  logic [DIV_W-1:0] cnt_q; // Clocks left in this period
  logic             tick_q;

  // Down counter that reloads at zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= divisor_i - 1'b1; // Period of divisor clocks
      tick_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_q <= 1'b0;
    end
  end

  assign tick_o = tick_q;

endmodule

`default_nettype wire

//--- verilog/uart_rx_sampler.sv
// Needs NR_SYNC_STAGES >= 2; the phase counter runs freely and only start edges realign it
`timescale 1ns/1ns
`default_nettype none

module uart_rx_sampler #(
  parameter int NR_SYNC_STAGES = 2
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire logic              rxd_i,
  input  wire logic              tick_i,   // Oversample tick
  input  wire logic              hunt_i,   // Framer waits for a start bit
  output logic                   start_o,
  output uart_rx_pkg::rx_sample_t sample_o
);
  import uart_rx_pkg::*;

  localparam int PHASE_W = $clog2(OVERSAMPLE);

  logic [NR_SYNC_STAGES-1:0] sync_q;
  logic                      sync_rxd;
  logic [PHASE_W-1:0]        phase_q;
  logic [1:0]                high_cnt_q; // Ones seen in the sample window
  logic [1:0]                high_sum;
  logic                      filt_q;
  logic                      center_q;

  // --------------------
  // Input synchronizer
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '1; // Idle line is high
    end else begin
      sync_q <= {sync_q[NR_SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign sync_rxd = sync_q[NR_SYNC_STAGES-1];

  // Falling line while hunting marks a start bit
  assign start_o = hunt_i & ~sync_rxd;

  // --------------------
  // Phase and filter
  // --------------------
  assign high_sum = high_cnt_q + {1'b0, sync_rxd}; // Includes the current sample

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q    <= '0;
      high_cnt_q <= '0;
      filt_q     <= 1'b1;
      center_q   <= 1'b0;
    end else begin
      center_q <= 1'b0;
      if (start_o) begin
        phase_q <= PHASE_W'(START_LOAD_PHASE); // Realign to the start edge
      end else if (tick_i) begin
        phase_q <= phase_q + 1'b1; // Wraps every bit
        // Open the window with a fresh count
        if (phase_q == PHASE_W'(SAMPLE_START_PHASE)) begin
          high_cnt_q <= {1'b0, sync_rxd};
        end else if (phase_q > PHASE_W'(SAMPLE_START_PHASE) &&
                     phase_q < PHASE_W'(SAMPLE_END_PHASE)) begin
          high_cnt_q <= high_sum;
        end
        // Two of three decides
        if (phase_q == PHASE_W'(SAMPLE_END_PHASE)) begin
          filt_q <= (high_sum >= 2'd2);
        end
        if (phase_q == PHASE_W'(CENTER_PHASE - 1)) begin
          center_q <= 1'b1; // Phase reaches the centre next clock
        end
      end
    end
  end

  assign sample_o.center = center_q;
  assign sample_o.value  = filt_q;

endmodule

`default_nettype wire

//--- verilog/uart_rx_framer.sv
// Checks only the first stop bit; a framing error costs one RESYNC clock before the next hunt
`timescale 1ns/1ns
`default_nettype none

module uart_rx_framer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire uart_rx_pkg::rx_cfg_t    cfg_i,
  input  wire logic                    start_i,
  input  wire uart_rx_pkg::rx_sample_t sample_i,
  output logic                         hunt_o,
  output logic                         push_o,
  output uart_rx_pkg::rx_char_t        char_o
);
  import uart_rx_pkg::*;

  rx_state_e  state_q;
  logic [2:0] bit_cnt_q;   // Next data bit index
  logic [2:0] last_bit;
  logic [7:0] rsr_q;       // Receive shift register, LSB first
  logic       par_err_q;
  logic       line_high_q; // Parity bit seen high, breaks out of a break
  logic       par_bad;
  logic       brk_now;
  logic       push_q;
  rx_char_t   char_q;

  // LEN5..LEN8 map to index 4..7
  assign last_bit = {1'b1, cfg_i.word_len};

  // --------------------
  // Parity check
  // --------------------
  always_comb begin
    case (cfg_i.par_mode)
      PAR_ODD:    par_bad = (^rsr_q == sample_i.value);
      PAR_EVEN:   par_bad = (^rsr_q != sample_i.value);
      PAR_FORCE1: par_bad = ~sample_i.value;
      PAR_FORCE0: par_bad = sample_i.value;
      default:    par_bad = 1'b0;
    endcase
  end

  // Data, parity and stop all low
  assign brk_now = ~line_high_q & ~(|rsr_q) & ~sample_i.value;

  // --------------------
  // Frame FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      bit_cnt_q   <= '0;
      par_err_q   <= 1'b0;
      line_high_q <= 1'b0;
      push_q      <= 1'b0;
    end else begin
      push_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) state_q <= START;
        end
        START: begin
          if (sample_i.center) begin
            if (!sample_i.value) begin // Start bit confirmed
              state_q     <= DATA;
              bit_cnt_q   <= '0;
              par_err_q   <= 1'b0;
              line_high_q <= 1'b0;
            end else begin
              state_q <= IDLE; // Glitch
            end
          end
        end
        DATA: begin
          if (sample_i.center) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == last_bit) begin
              state_q <= cfg_i.par_en ? PARITY : STOP;
            end
          end
        end
        PARITY: begin
          if (sample_i.center) begin
            par_err_q   <= par_bad;
            line_high_q <= line_high_q | sample_i.value;
            state_q     <= STOP;
          end
        end
        STOP: begin
          if (sample_i.center) begin
            push_q  <= 1'b1;
            state_q <= sample_i.value ? IDLE : RESYNC;
          end
        end
        RESYNC: state_q <= start_i ? START : IDLE; // Line may still be low
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (state_q == START && sample_i.center) begin
      rsr_q <= '0; // Upper bits stay zero for short words
    end else if (state_q == DATA && sample_i.center) begin
      rsr_q[bit_cnt_q] <= sample_i.value;
    end
    if (state_q == STOP && sample_i.center) begin
      char_q.data      <= rsr_q;
      char_q.par_err   <= par_err_q;
      char_q.frame_err <= ~sample_i.value;
      char_q.brk       <= brk_now;
    end
  end

  assign hunt_o = (state_q == IDLE) || (state_q == RESYNC);
  assign push_o = push_q;
  assign char_o = char_q;

endmodule

`default_nettype wire

//--- verilog/uart_rx_fifo.sv
// FIFO_DEPTH must be a power of two and at least 14 for every trigger level to be reachable
`timescale 1ns/1ns
`default_nettype none

module uart_rx_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  input  wire logic                     clear_i,
  input  wire logic                     push_i,
  input  wire uart_rx_pkg::rx_char_t    char_i,
  input  wire logic                     pop_i,
  input  wire uart_rx_pkg::trig_level_e trig_level_i,
  output uart_rx_pkg::rx_char_t         char_o,
  output logic                          valid_o,
  output logic                          trigger_o,
  output logic                          overrun_o
);
  import uart_rx_pkg::*;

  localparam int AW    = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  rx_char_t           mem [FIFO_DEPTH];
  logic [AW-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]   usage_q;
  logic [CNT_W-1:0]   trig_chars;
  logic               full, empty;
  logic               do_push, do_pop;
  logic               overrun_q;

  assign full    = (usage_q == CNT_W'(FIFO_DEPTH));
  assign empty   = (usage_q == '0);
  assign do_push = push_i & ~full;   // Dropped when full
  assign do_pop  = pop_i & ~empty;   // Ignored when empty

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      usage_q   <= '0;
      overrun_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // Pointers wrap
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      usage_q   <= usage_q + CNT_W'(do_push) - CNT_W'(do_pop);
      overrun_q <= push_i & full;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= char_i;
  end

  // --------------------
  // Trigger level
  // --------------------
  always_comb begin
    case (trig_level_i)
      TRIG1:   trig_chars = CNT_W'(1);
      TRIG4:   trig_chars = CNT_W'(4);
      TRIG8:   trig_chars = CNT_W'(8);
      TRIG14:  trig_chars = CNT_W'(14);
      default: trig_chars = CNT_W'(1);
    endcase
  end

  assign char_o    = mem[rd_ptr_q]; // Head, meaningful while valid
  assign valid_o   = ~empty;
  assign trigger_o = (usage_q >= trig_chars);
  assign overrun_o = overrun_q;

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
// Receive only; characters are lost on a full FIFO and overrun_o pulses, the line never stalls
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int NR_SYNC_STAGES = 2,
  parameter int FIFO_DEPTH     = 16
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire uart_rx_pkg::rx_cfg_t cfg_i,
  input  wire logic                 rxd_i,
  input  wire logic                 pop_i,        // Remove FIFO head
  input  wire logic                 fifo_clear_i,
  output uart_rx_pkg::rx_char_t     rx_char_o,
  output logic                      rx_valid_o,
  output logic                      trigger_o,
  output logic                      overrun_o
);
  import uart_rx_pkg::*;

  logic       tick;
  logic       hunt;
  logic       start;
  logic       push;
  rx_sample_t sample;
  rx_char_t   push_char;

  // --------------------
  // Receive chain
  // --------------------
  uart_rx_tick_gen u_tick_gen (
    .clk_i,
    .rst_i,
    .divisor_i (cfg_i.divisor),
    .tick_o    (tick)
  );

  uart_rx_sampler #(
    .NR_SYNC_STAGES (NR_SYNC_STAGES)
  ) u_sampler (
    .clk_i,
    .rst_i,
    .rxd_i,
    .tick_i   (tick),
    .hunt_i   (hunt),
    .start_o  (start),
    .sample_o (sample)
  );

  uart_rx_framer u_framer (
    .clk_i,
    .rst_i,
    .cfg_i,
    .start_i  (start),
    .sample_i (sample),
    .hunt_o   (hunt),
    .push_o   (push),
    .char_o   (push_char)
  );

  uart_rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i,
    .rst_i,
    .clear_i      (fifo_clear_i),
    .push_i       (push),
    .char_i       (push_char),
    .pop_i,
    .trig_level_i (cfg_i.trig_level),
    .char_o       (rx_char_o),
    .valid_o      (rx_valid_o),
    .trigger_o,
    .overrun_o
  );

endmodule

`default_nettype wire

//--- include/uart_rx_tb_model.svh
// Included inside uart_rx_tb after FIFO_DEPTH and the package import; one frame checked at a time
`ifndef UART_RX_TB_MODEL_SVH
`define UART_RX_TB_MODEL_SVH

rx_char_t exp_q[$]; // What the FIFO should hold, head first

// Run ends here on any failure
task automatic abort_run(string why);
  $display("TEST FAILED");
  $fatal(1, why);
endtask

function automatic string char_str(rx_char_t c);
  return $sformatf("{par_err %b frame_err %b brk %b data %h}",
                   c.par_err, c.frame_err, c.brk, c.data);
endfunction

// --------------------
// Expected character from the line bits
function automatic rx_char_t expect_char(rx_cfg_t cfg, logic [7:0] data, logic par_bit,
                                         logic stop_bit);
  rx_char_t   c;
  logic [7:0] d;
  d           = data & (8'hFF >> (3 - int'(cfg.word_len))); // Only word_len bits are sent
  c.data      = d;
  c.frame_err = ~stop_bit;
  c.brk       = (d == 8'h00) && !(cfg.par_en && par_bit) && !stop_bit; // Whole frame low
  c.par_err   = 1'b0;
  if (cfg.par_en) begin
    case (cfg.par_mode)
      PAR_ODD:    c.par_err = ((^d) == par_bit); // Ones count comes out even
      PAR_EVEN:   c.par_err = ((^d) != par_bit);
      PAR_FORCE1: c.par_err = ~par_bit;
      default:    c.par_err = par_bit;           // Forced 0
    endcase
  end
  return c;
endfunction

// Returns 1 when the FIFO is full and the character is lost
function automatic logic queue_char(rx_char_t c);
  if (exp_q.size() >= FIFO_DEPTH) return 1'b1;
  exp_q.push_back(c);
  return 1'b0;
endfunction

task automatic flush_model();
  exp_q.delete();
endtask

// --------------------
task automatic check_char(string name, rx_char_t expected, rx_char_t actual);
  if (expected !== actual) begin
    $display("Fail %s: expected %s actual %s", name, char_str(expected), char_str(actual));
    abort_run("Received character differs from the model");
  end
endtask

task automatic check_flag(string name, logic expected, logic actual);
  if (expected !== actual) begin
    $display("Fail %s: expected %b actual %b", name, expected, actual);
    abort_run("Status flag differs from the model");
  end
endtask

`endif

//--- testbench/uart_rx_tb.sv
// Needs a timing-capable simulator; a low stop bit is re-read as a start bit, so 12 idle bits follow
`timescale 1ns/1ns
`default_nettype none

module uart_rx_tb;
  import uart_rx_pkg::*;

  localparam int FIFO_DEPTH = 16;
  localparam int N_CLEAN    = 24;
  localparam int N_PARITY   = 24;
  localparam int N_FRAME    = 10;
  localparam int N_TRIG     = 2 + 5 + 9 + 15;  // Level plus one for each level
  localparam int N_CHARS    = N_CLEAN + N_PARITY + 2 * N_FRAME + N_TRIG + FIFO_DEPTH + 6;
  localparam int MAX_CYCLES = N_CHARS * 12 * 16 * 5 * 2; // 12 bits at divisor 5 with 2x margin

  logic        clk;
  logic        rst;
  rx_cfg_t     cfg;
  logic        rxd;
  logic        pop;
  logic        fifo_clear;
  rx_char_t    rx_char;
  logic        rx_valid;
  logic        trigger;
  logic        overrun;
  logic [31:0] rng;     // xorshift state
  int          cycles;
  int          ovr_cnt; // Overrun pulses so far

  `include "uart_rx_tb_model.svh"

  uart_rx #(.NR_SYNC_STAGES(2), .FIFO_DEPTH(FIFO_DEPTH)) dut_i (
    .clk_i(clk), .rst_i(rst), .cfg_i(cfg), .rxd_i(rxd), .pop_i(pop),
    .fifo_clear_i(fifo_clear), .rx_char_o(rx_char), .rx_valid_o(rx_valid),
    .trigger_o(trigger), .overrun_o(overrun)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) abort_run("Timeout, the tests did not finish in time");
  end

  always @(negedge clk) begin
    if (overrun) ovr_cnt <= ovr_cnt + 1; // One-clock pulse
  end

  // --------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'(next_rand() % 32'(hi - lo + 1));
  endfunction

  // New random config while the line idles
  task automatic pick_cfg(logic par_en);
    logic [31:0] r;
    r              = next_rand();
    cfg.divisor    = DIV_W'(rand_range(2, 5));
    cfg.word_len   = word_len_e'(r[1:0]);
    cfg.par_mode   = par_mode_e'(r[3:2]);
    cfg.trig_level = trig_level_e'(r[5:4]);
    cfg.par_en     = par_en;
    @(posedge clk);
    #1;
  endtask

  task automatic hold_bit(logic b);
    rxd = b;
    repeat (16 * int'(cfg.divisor)) @(posedge clk); // 16 ticks per bit
    #1;
  endtask

  // Start, data LSB first, parity, stop, idle
  task automatic send_frame(logic [7:0] data, logic par_bit, logic stop_bit, int idle_bits);
    hold_bit(1'b0);
    for (int i = 0; i < int'(cfg.word_len) + 5; i++) hold_bit(data[i]);
    if (cfg.par_en) hold_bit(par_bit);
    hold_bit(stop_bit);
    repeat (idle_bits) hold_bit(1'b1);
  endtask

  // ovr is 1 when this character should overrun the FIFO
  task automatic send_char(logic [7:0] data, logic par_flip, logic stop_bit, output logic ovr);
    logic [7:0] d;
    logic       par_bit;
    d = data & (8'hFF >> (3 - int'(cfg.word_len)));
    case (cfg.par_mode)
      PAR_ODD:    par_bit = ~^d;
      PAR_EVEN:   par_bit = ^d;
      PAR_FORCE1: par_bit = 1'b1;
      default:    par_bit = 1'b0;
    endcase
    par_bit = par_bit ^ par_flip; // Corrupted on request
    ovr = queue_char(expect_char(cfg, data, par_bit, stop_bit));
    // Low stop bit restarts the framer and the idle line reads as all ones
    if (!stop_bit) void'(queue_char(expect_char(cfg, 8'hFF, 1'b1, 1'b1)));
    send_frame(data, par_bit, stop_bit, stop_bit ? 1 : 12);
  endtask

  // Pops and compares everything queued
  task automatic drain(string name);
    int wait_cycles;
    while (exp_q.size() > 0) begin
      wait_cycles = 0;
      while (!rx_valid) begin
        @(posedge clk);
        #1;
        wait_cycles++;
        if (wait_cycles > 16 * 5 * 24) abort_run({name, ": no character reached the FIFO"});
      end
      check_char(name, exp_q.pop_front(), rx_char);
      pop = 1'b1;
      @(posedge clk);
      #1;
      pop = 1'b0;
    end
    check_flag({name, " empty"}, 1'b0, rx_valid);
  endtask

  // --------------------
  initial begin
    logic        ovr;
    logic [31:0] r;
    int          lvl_chars;
    int          cnt_before;
    rng        = 32'd56818;
    rst        = 1'b1;
    rxd        = 1'b1; // Idle line
    pop        = 1'b0;
    fifo_clear = 1'b0;
    cfg        = '{divisor: DIV_W'(4), word_len: LEN8, par_en: 1'b0, par_mode: PAR_ODD,
                   trig_level: TRIG1};
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < N_CLEAN; i++) begin
      pick_cfg(1'b0);
      r = next_rand();
      send_char(r[7:0], 1'b0, 1'b1, ovr);
      drain("clean");
    end

    for (int i = 0; i < N_PARITY; i++) begin
      pick_cfg(1'b1);
      r = next_rand();
      send_char(r[7:0], r[8], 1'b1, ovr); // Parity flipped half the time
      drain("parity");
    end

    // Every other frame all zero and three in four with a low stop bit
    for (int i = 0; i < N_FRAME; i++) begin
      r = next_rand();
      pick_cfg(r[9]);
      send_char((i % 2 == 0) ? 8'h00 : r[7:0], r[8], (i % 4 == 3), ovr);
      drain("framing");
    end

    for (int lvl = 0; lvl < 4; lvl++) begin
      pick_cfg(1'b0);
      cfg.trig_level = trig_level_e'(2'(lvl));
      lvl_chars = (lvl == 0) ? 1 : (lvl == 1) ? 4 : (lvl == 2) ? 8 : 14;
      check_flag("trigger empty", 1'b0, trigger);
      for (int n = 1; n <= lvl_chars + 1; n++) begin
        r = next_rand();
        send_char(r[7:0], 1'b0, 1'b1, ovr);
        check_flag("trigger", exp_q.size() >= lvl_chars, trigger);
      end
      drain("trigger");
    end

    // One past full
    pick_cfg(1'b1);
    cnt_before = ovr_cnt;
    for (int n = 0; n <= FIFO_DEPTH; n++) begin
      r = next_rand();
      lvl_chars = ovr_cnt;
      send_char(r[7:0], 1'b0, 1'b1, ovr);
      check_flag("overrun", ovr, ovr_cnt != lvl_chars);
    end
    check_flag("overrun once", 1'b1, (ovr_cnt - cnt_before) == 1);
    drain("overrun");

    pick_cfg(1'b0);
    cfg.trig_level = TRIG4;
    for (int n = 0; n < 4; n++) begin
      r = next_rand();
      send_char(r[7:0], 1'b0, 1'b1, ovr);
    end
    check_flag("valid before clear", 1'b1, rx_valid);
    check_flag("trigger before clear", 1'b1, trigger);
    fifo_clear = 1'b1;
    @(posedge clk);
    #1;
    fifo_clear = 1'b0;
    flush_model();
    check_flag("valid after clear", 1'b0, rx_valid);
    check_flag("trigger after clear", 1'b0, trigger);
    r = next_rand();
    send_char(r[7:0], 1'b0, 1'b1, ovr);
    drain("after clear");

    // Only the full FIFO may ever have dropped a character
    if (ovr_cnt != 1) begin
      abort_run("Overrun pulsed while the FIFO was not full");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
verilog/uart_rx_pkg.sv
verilog/uart_rx_tick_gen.sv
verilog/uart_rx_sampler.sv
verilog/uart_rx_framer.sv
verilog/uart_rx_fifo.sv
verilog/uart_rx.sv
testbench/uart_rx_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, then pass only if the simulation prints the pass message
verilator --binary -j 0 --top-module uart_rx_tb -f src.f \
  && ./obj_dir/Vuart_rx_tb | grep "TEST OK" \
  && exit 0 || exit 1
